// File: hw/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Core side widths
`define CACHE_ADDR_W      32
`define CACHE_WORD_W      64

// Line and set geometry
`define CACHE_LINE_W      256
`define CACHE_INDEX_W     6
`define CACHE_OFFSET_W    5
`define CACHE_TAG_W       21
`define CACHE_WAYS        2
`define CACHE_LINE_BYTES  32

// Memory bus fields
`define BUS_TYPE_W        6
`define BUS_STRB_W        16

// Full line burst on either channel
`define BUS_TYPE_LINE     31

`endif

// File: hw/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    // Address and data
    typedef logic [`CACHE_ADDR_W-1:0]     addr_t;
    typedef logic [`CACHE_WORD_W-1:0]     word_t;
    typedef logic [`CACHE_LINE_W-1:0]     line_t;

    // Address split into tag, set and byte
    typedef logic [`CACHE_TAG_W-1:0]      tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]    index_t;
    typedef logic [`CACHE_OFFSET_W-1:0]   offset_t;

    // Size code 0..3 for 1, 2, 4 or 8 bytes
    typedef logic [1:0]                   len_t;

    typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;
    typedef logic [`CACHE_WAYS-1:0]       way_mask_t;

    // Memory bus sideband
    typedef logic [`BUS_TYPE_W-1:0]       bus_type_t;
    typedef logic [`BUS_STRB_W-1:0]       bus_strb_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE, LOOKUP, MISS, REPLACE, REFILL, WRITE
    } cache_state_e;

endpackage

`default_nettype wire

// File: hw/cache_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

// Tag store access between controller and tag array
interface tag_if import cache_pkg::*;;
    index_t                      index;
    logic                        rd_en;
    // Update side
    way_mask_t                   upd_way;
    logic                        upd_tag;
    logic                        upd_dirty;
    tag_t                        new_tag;
    logic                        new_dirty;
    // Registered read data per way
    tag_t [`CACHE_WAYS-1:0]      rd_tag;
    way_mask_t                   rd_valid;
    way_mask_t                   rd_dirty;

    modport ctrl (
        output index, rd_en, upd_way, upd_tag, upd_dirty, new_tag, new_dirty,
        input  rd_tag, rd_valid, rd_dirty
    );

    modport array (
        input  index, rd_en, upd_way, upd_tag, upd_dirty, new_tag, new_dirty,
        output rd_tag, rd_valid, rd_dirty
    );
endinterface

// Line store access between controller and data array
interface data_if import cache_pkg::*;;
    index_t                      index;
    logic                        rd_en;
    way_mask_t                   wr_way;
    byte_mask_t                  byte_en;
    line_t                       wdata;
    // Both ways come back together
    line_t [`CACHE_WAYS-1:0]     rd_line;

    modport ctrl (
        output index, rd_en, wr_way, byte_en, wdata,
        input  rd_line
    );

    modport array (
        input  index, rd_en, wr_way, byte_en, wdata,
        output rd_line
    );
endinterface

`default_nettype wire

// File: hw/tag_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module tag_array import cache_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    tag_if.array tags
);

    localparam int SETS = 1 << `CACHE_INDEX_W;

    // Tag bits live in plain storage
    tag_t tag_mem [`CACHE_WAYS][SETS];

    // State bits per way and set
    logic [`CACHE_WAYS-1:0][SETS-1:0] valid_q;
    logic [`CACHE_WAYS-1:0][SETS-1:0] dirty_q;

    //////////////////////////////
    // Valid and dirty update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (tags.upd_way[w] && tags.upd_tag) begin
                    valid_q[w][tags.index] <= 1'b1;
                end
                if (tags.upd_way[w] && tags.upd_dirty) begin
                    dirty_q[w][tags.index] <= tags.new_dirty;
                end
            end
        end
    end

    //////////////////////////////
    // Tag write and registered read
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (tags.upd_way[w] && tags.upd_tag) begin
                tag_mem[w][tags.index] <= tags.new_tag;
            end
            // All ways read at once for the compare
            if (tags.rd_en) begin
                tags.rd_tag[w]   <= tag_mem[w][tags.index];
                tags.rd_valid[w] <= valid_q[w][tags.index];
                tags.rd_dirty[w] <= dirty_q[w][tags.index];
            end
        end
    end

    // Refill and store hit each touch a single way
    a_upd_one_way: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(tags.upd_way));

endmodule

`default_nettype wire

// File: hw/data_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module data_array import cache_pkg::*; (
    input  logic  clk,
    data_if.array data
);

    localparam int SETS = 1 << `CACHE_INDEX_W;

    // One line per way and set
    line_t line_mem [`CACHE_WAYS][SETS];

    //////////////////////////////
    // Byte enabled write
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (data.wr_way[w]) begin
                for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
                    if (data.byte_en[b]) begin
                        line_mem[w][data.index][8*b +: 8] <= data.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Read of both ways
    always_ff @(posedge clk) begin
        if (data.rd_en) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                data.rd_line[w] <= line_mem[w][data.index];
            end
        end
    end

    // Controller never writes two ways in one cycle
    a_wr_one_way: assert property (@(posedge clk)
        $onehot0(data.wr_way));

    // Writes land after the read data has been used
    a_no_rd_wr: assert property (@(posedge clk)
        (data.wr_way != '0) |-> !data.rd_en);

endmodule

`default_nettype wire

// File: hw/line_align.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module line_align import cache_pkg::*; (
    input  offset_t    offset,
    input  len_t       len,
    input  word_t      store,
    input  line_t      base,
    input  line_t      line,
    output word_t      load,
    output byte_mask_t byte_en,
    output line_t      merged
);

    byte_mask_t size_mask;
    line_t      store_line;
    logic [7:0] bit_shift;

    // Byte offset as a bit count
    assign bit_shift = {offset, 3'b000};

    // Mask of the access size at byte 0
    always_comb begin
        case (len)
            2'd0:    size_mask = byte_mask_t'(8'h01);
            2'd1:    size_mask = byte_mask_t'(8'h03);
            2'd2:    size_mask = byte_mask_t'(8'h0f);
            default: size_mask = byte_mask_t'(8'hff);
        endcase
    end

    assign byte_en = size_mask << offset;

    //////////////////////////////
    // Store side
    assign store_line = line_t'(store) << bit_shift;

    always_comb begin
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            merged[8*b +: 8] = byte_en[b] ? store_line[8*b +: 8] : base[8*b +: 8];
        end
    end

    //////////////////////////////
    // Load side
    // Shift pulls in zeros past the line end
    assign load = word_t'(line >> bit_shift);

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    tag_if.ctrl       tags,
    data_if.ctrl      data,
    // Core port
    input  addr_t     addr,
    input  word_t     data_in,
    input  logic      valid_in,
    input  logic      write,
    input  len_t      len,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     data_out,
    // Memory read channel
    output logic      r_req,
    output bus_type_t r_type,
    output addr_t     r_addr,
    input  logic      r_rdy,
    input  line_t     re_data,
    input  logic      re_valid,
    // Memory write channel
    output logic      w_req,
    output addr_t     w_addr,
    output line_t     w_data,
    output bus_type_t w_type,
    output bus_strb_t w_strb,
    input  logic      w_rdy
);

    cache_state_e state, state_next;

    // Accepted request
    addr_t     req_addr;
    word_t     req_data;
    len_t      req_len;
    logic      req_write;
    tag_t      req_tag;
    index_t    req_index;
    offset_t   req_offset;

    // Lookup results
    way_mask_t hit_way, hit_way_q;
    logic      hit, hit_read, accept;
    line_t     hit_line;

    // Victim picked in lookup
    logic      toggle;
    way_mask_t victim_way_q;
    tag_t      victim_tag_q;
    logic      victim_dirty_q;
    line_t     victim_line_q;

    // Aligner results
    line_t      align_src, merged;
    byte_mask_t align_en;

    assign {req_tag, req_index, req_offset} = req_addr;

    //////////////////////////////
    // Hit detection
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_way[w] = tags.rd_valid[w] && (tags.rd_tag[w] == req_tag);
            if (hit_way[w]) begin
                hit_line = hit_line | data.rd_line[w];
            end
        end
    end

    assign hit      = (state == LOOKUP) && (hit_way != '0);
    assign hit_read = hit && !req_write;
    assign addr_ok  = (state == IDLE) || hit_read;
    assign accept   = valid_in && addr_ok;
    assign data_ok  = hit_read || ((state == REFILL) && re_valid && !req_write);

    //////////////////////////////
    // FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            toggle <= 1'b0;
        end else begin
            state <= state_next;
            // Flips on every lookup
            if (state == LOOKUP) begin
                toggle <= ~toggle;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (valid_in) state_next = LOOKUP;
            LOOKUP: begin
                if (!hit)           state_next = MISS;
                else if (req_write) state_next = WRITE;
                else if (valid_in)  state_next = LOOKUP;
                else                state_next = IDLE;
            end
            // Clean victim skips the writeback
            MISS:    if (w_rdy || !victim_dirty_q) state_next = REPLACE;
            REPLACE: if (r_rdy) state_next = REFILL;
            REFILL:  if (re_valid) state_next = IDLE;
            WRITE:   state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    //////////////////////////////
    // Request and victim capture
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr;
            req_data  <= data_in;
            req_len   <= len;
            req_write <= write;
        end
        if (state == LOOKUP) begin
            hit_way_q      <= hit_way;
            victim_way_q   <= way_mask_t'(1) << toggle;
            victim_tag_q   <= tags.rd_tag[toggle];
            victim_dirty_q <= tags.rd_valid[toggle] && tags.rd_dirty[toggle];
            victim_line_q  <= data.rd_line[toggle];
        end
    end

    //////////////////////////////
    // Array control
    always_comb begin
        // Reads use the incoming set while a request can be taken
        tags.rd_en     = addr_ok;
        tags.index     = addr_ok ? addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : req_index;
        tags.upd_way   = '0;
        tags.upd_tag   = 1'b0;
        tags.upd_dirty = 1'b0;
        tags.new_tag   = req_tag;
        tags.new_dirty = 1'b1;
        data.rd_en     = addr_ok;
        data.index     = tags.index;
        data.wr_way    = '0;
        data.byte_en   = align_en;
        data.wdata     = merged;
        if (state == REFILL && re_valid) begin
            // New line is dirty only when a store allocated it
            tags.upd_way   = victim_way_q;
            tags.upd_tag   = 1'b1;
            tags.upd_dirty = 1'b1;
            tags.new_dirty = req_write;
            data.wr_way    = victim_way_q;
            data.byte_en   = '1;
            data.wdata     = req_write ? merged : re_data;
        end else if (state == WRITE) begin
            tags.upd_way   = hit_way_q;
            tags.upd_dirty = 1'b1;
            data.wr_way    = hit_way_q;
        end
    end

    // Hit data in lookup and bus data in refill
    assign align_src = (state == LOOKUP) ? hit_line : re_data;

    line_align u_line_align (
        .offset  (req_offset),
        .len     (req_len),
        .store   (req_data),
        .base    (re_data),
        .line    (align_src),
        .load    (data_out),
        .byte_en (align_en),
        .merged  (merged)
    );

    //////////////////////////////
    // Memory bus
    assign w_req  = (state == MISS) && victim_dirty_q;
    assign w_addr = {victim_tag_q, req_index, {`CACHE_OFFSET_W{1'b0}}};
    assign w_data = victim_line_q;
    assign w_type = w_req ? bus_type_t'(`BUS_TYPE_LINE) : '0;
    assign w_strb = w_req ? '1 : '0;

    assign r_req  = (state == REPLACE);
    assign r_addr = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
    assign r_type = r_req ? bus_type_t'(`BUS_TYPE_LINE) : '0;

    a_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
        !(r_req && w_req));

    // Access must stay inside one line
    a_in_line: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (({1'b0, addr[`CACHE_OFFSET_W-1:0]} + (6'd1 << len))
                    <= 6'(`CACHE_LINE_BYTES)));

endmodule

`default_nettype wire

// File: hw/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_top import cache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // Core side
    input  addr_t     addr,
    input  word_t     data_in,
    input  logic      valid_in,
    input  logic      write,
    input  len_t      len,
    output logic      addr_ok,
    output logic      data_ok,
    output word_t     data_out,
    // Line reads
    output logic      r_req,
    output bus_type_t r_type,
    output addr_t     r_addr,
    input  logic      r_rdy,
    input  line_t     re_data,
    input  logic      re_valid,
    // Line writebacks
    output logic      w_req,
    output addr_t     w_addr,
    output line_t     w_data,
    output bus_type_t w_type,
    output bus_strb_t w_strb,
    input  logic      w_rdy
);

    //////////////////////////////
    // Array links
    tag_if  u_tag_if ();
    data_if u_data_if ();

    // Tags with valid and dirty state
    tag_array u_tag_array (
        .clk   (clk),
        .rst_n (rst_n),
        .tags  (u_tag_if.array)
    );

    // Line storage of both ways
    data_array u_data_array (
        .clk  (clk),
        .data (u_data_if.array)
    );

    //////////////////////////////
    // Controller
    cache_ctrl u_cache_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .tags     (u_tag_if.ctrl),
        .data     (u_data_if.ctrl),
        .addr     (addr),
        .data_in  (data_in),
        .valid_in (valid_in),
        .write    (write),
        .len      (len),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .data_out (data_out),
        .r_req    (r_req),
        .r_type   (r_type),
        .r_addr   (r_addr),
        .r_rdy    (r_rdy),
        .re_data  (re_data),
        .re_valid (re_valid),
        .w_req    (w_req),
        .w_addr   (w_addr),
        .w_data   (w_data),
        .w_type   (w_type),
        .w_strb   (w_strb),
        .w_rdy    (w_rdy)
    );

endmodule

`default_nettype wire

// File: test/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cache_defs.svh"

module cache_tb import cache_pkg::*; ();

    localparam int SEED         = 73492;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_OPS   = 60;
    // Core operations over all tests
    localparam int PLANNED_OPS  = 130;
    localparam int CYCLE_LIMIT  = PLANNED_OPS * 40 + RESET_CYCLES;

    logic      clk;
    logic      rst_n;
    addr_t     addr;
    word_t     data_in;
    logic      valid_in;
    logic      write;
    len_t      len;
    logic      addr_ok;
    logic      data_ok;
    word_t     data_out;
    logic      r_req;
    bus_type_t r_type;
    addr_t     r_addr;
    logic      r_rdy;
    line_t     re_data;
    logic      re_valid;
    logic      w_req;
    addr_t     w_addr;
    line_t     w_data;
    bus_type_t w_type;
    bus_strb_t w_strb;
    logic      w_rdy;

    // Bookkeeping
    int        checks = 0;
    int        errors = 0;
    int        rd_count = 0;
    int        wr_count = 0;
    addr_t     last_r_addr;
    addr_t     last_w_addr;

    // Backing memory by line and expected bytes by address
    line_t      mem [addr_t];
    logic [7:0] shadow [addr_t];

    cache_top u_cache_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Reference helpers
    function automatic logic [7:0] fill_byte(input addr_t a);
        addr_t h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ a[7:0];
    endfunction

    function automatic logic [7:0] shadow_byte(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_byte(a);
    endfunction

    function automatic line_t shadow_line(input addr_t la);
        line_t l;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            l[8*b +: 8] = shadow_byte(la + addr_t'(b));
        end
        return l;
    endfunction

    function automatic line_t memory_line(input addr_t la);
        line_t l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            l[8*b +: 8] = fill_byte(la + addr_t'(b));
        end
        return l;
    endfunction

    // Eight bytes from the offset with zeros past the line end
    function automatic word_t expected_word(input addr_t a);
        word_t w;
        int    off;
        w   = '0;
        off = int'(a[`CACHE_OFFSET_W-1:0]);
        for (int i = 0; i < 8; i++) begin
            if (off + i < `CACHE_LINE_BYTES) begin
                w[8*i +: 8] = shadow_byte(a + addr_t'(i));
            end
        end
        return w;
    endfunction

    function automatic addr_t addr_of(input int tag, input int set, input int off);
        return (addr_t'(tag) << (`CACHE_OFFSET_W + `CACHE_INDEX_W))
             | (addr_t'(set) << `CACHE_OFFSET_W) | addr_t'(off);
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return a & ~addr_t'(`CACHE_LINE_BYTES - 1);
    endfunction

    task automatic compare(input string name, input logic [255:0] got,
                           input logic [255:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    //////////////////////////////
    // Memory read channel
    initial begin : read_channel
        int delay;
        r_rdy    = 1'b0;
        re_valid = 1'b0;
        re_data  = '0;
        forever begin
            @(negedge clk);
            if (r_req) begin
                compare("r_addr low bits", r_addr[`CACHE_OFFSET_W-1:0], '0);
                compare("r_type", r_type, `BUS_TYPE_LINE);
                last_r_addr = r_addr;
                delay = $urandom_range(5);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                r_rdy <= 1'b1;
                @(posedge clk);
                r_rdy <= 1'b0;
                rd_count++;
                // Line comes back 1 to 6 cycles after the accept
                repeat ($urandom_range(6, 1) - 1) @(posedge clk);
                re_data  <= memory_line(last_r_addr);
                re_valid <= 1'b1;
                @(posedge clk);
                re_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Memory write channel
    initial begin : write_channel
        int delay;
        w_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (w_req) begin
                compare("w_strb", w_strb, {`BUS_STRB_W{1'b1}});
                compare("w_type", w_type, `BUS_TYPE_LINE);
                compare("w_addr low bits", w_addr[`CACHE_OFFSET_W-1:0], '0);
                // Victim holds every store made to it
                compare("w_data", w_data, shadow_line(w_addr));
                last_w_addr = w_addr;
                mem[w_addr] = w_data;
                wr_count++;
                delay = $urandom_range(5);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                w_rdy <= 1'b1;
                @(posedge clk);
                w_rdy <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // One core access and its cycles from accept to completion
    task automatic access(input logic wr, input addr_t a, input len_t l,
                          input word_t wd, output int lat);
        word_t exp;
        @(posedge clk);
        valid_in <= 1'b1;
        write    <= wr;
        addr     <= a;
        len      <= l;
        data_in  <= wd;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        // Taken on this edge
        @(posedge clk);
        valid_in <= 1'b0;
        lat = 0;
        if (wr) begin
            for (int i = 0; i < (1 << l); i++) begin
                shadow[a + addr_t'(i)] = wd[8*i +: 8];
            end
            do begin
                @(negedge clk);
                lat++;
                require(!data_ok, "data_ok pulsed for a write request");
            end while (!addr_ok);
        end else begin
            exp = expected_word(a);
            do begin
                @(negedge clk);
                lat++;
            end while (!data_ok);
            compare("data_out", data_out, exp);
        end
    endtask

    task automatic after_reset();
        @(negedge clk);
        compare("addr_ok", addr_ok, 1'b1);
        compare("data_ok", data_ok, 1'b0);
        compare("r_req", r_req, 1'b0);
        compare("w_req", w_req, 1'b0);
    endtask

    task automatic read_miss_then_hits();
        int lat;
        int r0;
        int w0;
        r0 = rd_count;
        w0 = wr_count;
        access(1'b0, addr_of(5, 1, 8), 2'd3, '0, lat);
        compare("r_req count", rd_count - r0, 1);
        compare("w_req count", wr_count - w0, 0);
        compare("r_addr", last_r_addr, addr_of(5, 1, 0));
        // Hit near the line end reads zeros above byte 31
        r0 = rd_count;
        access(1'b0, addr_of(5, 1, 28), 2'd2, '0, lat);
        compare("data_ok latency", lat, 1);
        compare("r_req count", rd_count - r0, 0);
        // Two hits back to back
        @(posedge clk);
        valid_in <= 1'b1;
        write    <= 1'b0;
        addr     <= addr_of(5, 1, 0);
        len      <= 2'd3;
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        @(posedge clk);
        addr <= addr_of(5, 1, 30);
        len  <= 2'd1;
        @(negedge clk);
        require(data_ok && addr_ok, "first back-to-back hit gave no data_ok with addr_ok");
        compare("data_out", data_out, expected_word(addr_of(5, 1, 0)));
        @(posedge clk);
        valid_in <= 1'b0;
        @(negedge clk);
        require(data_ok, "second back-to-back hit gave no data_ok");
        compare("data_out", data_out, expected_word(addr_of(5, 1, 30)));
    endtask

    task automatic stores_all_sizes();
        int    lat;
        int    r0;
        int    w0;
        int    off;
        addr_t a;
        // Line of set 3 kept resident for store hits
        access(1'b0, addr_of(40, 3, 0), 2'd3, '0, lat);
        for (int l = 0; l < 4; l++) begin
            for (int k = 0; k < 2; k++) begin
                off = (7 * l + 11 * k) % (33 - (1 << l));
                // Store miss allocates a new line
                a = addr_of(10 + 2 * l + k, 2, off);
                access(1'b1, a, len_t'(l), {$urandom, $urandom}, lat);
                access(1'b0, a, len_t'(l), '0, lat);
                // Store hit stays off the bus
                a  = addr_of(40, 3, off);
                r0 = rd_count;
                w0 = wr_count;
                access(1'b1, a, len_t'(l), {$urandom, $urandom}, lat);
                compare("r_req count", rd_count - r0, 0);
                compare("w_req count", wr_count - w0, 0);
                access(1'b0, a, len_t'(l), '0, lat);
            end
        end
    endtask

    task automatic dirty_eviction();
        int    lat;
        int    r0;
        int    w0;
        logic  settled;
        addr_t evicted;
        settled = 1'b0;
        // Both lines dirty once both stores hit
        for (int i = 0; i < 6 && !settled; i++) begin
            r0 = rd_count;
            access(1'b1, addr_of(70, 4, i), 2'd0, {$urandom, $urandom}, lat);
            access(1'b1, addr_of(71, 4, i + 3), 2'd1, {$urandom, $urandom}, lat);
            settled = (rd_count == r0);
        end
        require(settled, "set 4 never held both dirty lines");
        r0 = rd_count;
        w0 = wr_count;
        access(1'b0, addr_of(72, 4, 16), 2'd3, '0, lat);
        compare("w_req count", wr_count - w0, 1);
        compare("r_req count", rd_count - r0, 1);
        evicted = last_w_addr;
        require(evicted == addr_of(70, 4, 0) || evicted == addr_of(71, 4, 0),
                "writeback address is not one of the two dirty lines");
        access(1'b0, evicted, 2'd3, '0, lat);
        access(1'b0, evicted + 8, 2'd3, '0, lat);
    endtask

    task automatic clean_eviction();
        int   lat;
        int   r0;
        int   w0;
        logic settled;
        settled = 1'b0;
        for (int i = 0; i < 6 && !settled; i++) begin
            r0 = rd_count;
            access(1'b0, addr_of(80, 5, 4), 2'd2, '0, lat);
            access(1'b0, addr_of(81, 5, 12), 2'd2, '0, lat);
            settled = (rd_count == r0);
        end
        require(settled, "set 5 never held both clean lines");
        r0 = rd_count;
        w0 = wr_count;
        access(1'b0, addr_of(82, 5, 0), 2'd3, '0, lat);
        compare("w_req count", wr_count - w0, 0);
        compare("r_req count", rd_count - r0, 1);
    endtask

    task automatic random_traffic();
        int   lat;
        int   l;
        int   off;
        logic wr;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            l   = $urandom_range(3);
            off = $urandom_range(`CACHE_LINE_BYTES - (1 << l));
            wr  = $urandom_range(1);
            access(wr, addr_of(90 + $urandom_range(2), 8 + $urandom_range(1), off),
                   len_t'(l), {$urandom, $urandom}, lat);
        end
    endtask

    //////////////////////////////
    // Watchdog
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: cache still busy after %0d cycles", cycles);
        $display("Checks: %0d  Errors: %0d", checks, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    initial begin : main
        void'($urandom(SEED));
        rst_n    <= 1'b0;
        addr     <= '0;
        data_in  <= '0;
        valid_in <= 1'b0;
        write    <= 1'b0;
        len      <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        after_reset();
        read_miss_then_hits();
        stores_all_sizes();
        dirty_eviction();
        clean_eviction();
        random_traffic();
        repeat (4) @(posedge clk);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_if.sv
hw/tag_array.sv
hw/data_array.sv
hw/line_align.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = cache_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
